/* hw/img_capture_config.svh */
`ifndef IMG_CAPTURE_CONFIG_SVH
`define IMG_CAPTURE_CONFIG_SVH

// Header words sent ahead of every frame
`define IMG_HEADER_WORDS 4

// Output word and sensor pixel widths
`define IMG_WORD_BITS 16
`define IMG_PIXEL_BITS 12

// Statistics and word counter widths
`define IMG_STAT_BITS 18
`define IMG_COUNT_BITS 24

// Top pixel bits tested for highlight or shadow
`define IMG_STAT_TOP_BITS 7

`endif

/* hw/img_capture_pkg.sv */
`default_nettype none

`include "img_capture_config.svh"

package img_capture_pkg;

    // ====================
    // Command and inputs
    // ====================
    typedef struct packed {
        logic                                        capture;
        logic                                        skip_count;
        logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header;
    } capture_cmd_t;

    typedef struct packed {
        logic                       fv;
        logic                       lv;
        logic [`IMG_PIXEL_BITS-1:0] d;
    } pixel_bus_t;

    // Derived from the registered pixel bus
    typedef struct packed {
        logic frame_start;
        logic line_active;
        logic stat_sample;
    } frame_pos_t;

    // ====================
    // Output word
    // ====================
    // Little-endian pixel layout
    typedef struct packed {
        logic [7:0]                                lo_byte;
        logic [`IMG_WORD_BITS-`IMG_PIXEL_BITS-1:0] pad;
        logic [`IMG_PIXEL_BITS-9:0]                hi_nibble;
    } pixel_word_t;

    typedef union packed {
        logic [`IMG_WORD_BITS-1:0] raw;
        pixel_word_t               pixel;
    } capture_word_u;

    typedef enum logic [1:0] {
        WORD_NONE,
        WORD_HEADER,
        WORD_PIXEL,
        WORD_CHECKSUM
    } word_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_HEADER,
        ST_WAIT_FRAME,
        ST_FRAME,
        ST_CHECKSUM,
        ST_NEXT
    } capture_state_e;

    typedef struct packed {
        logic [`IMG_COUNT_BITS-1:0] word_count;
        logic [`IMG_STAT_BITS-1:0]  highlight_count;
        logic [`IMG_STAT_BITS-1:0]  shadow_count;
    } capture_stats_t;

endpackage

`default_nettype wire

/* hw/frame_position_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_position_counter (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  img_capture_pkg::pixel_bus_t pix,
    output img_capture_pkg::pixel_bus_t pix_q,
    output img_capture_pkg::frame_pos_t pos
);
    logic       fv_prev;
    logic       lv_prev;
    logic [1:0] x;
    logic [1:0] y;

    // Sample the sensor bus and keep the previous fv/lv
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            pix_q   <= '0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            pix_q   <= pix;
            fv_prev <= pix_q.fv;
            lv_prev <= pix_q.lv;
        end
    end

    // 2-bit grid position, x along the line and y over lines
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            x <= '0;
            y <= '0;
        end else begin
            if (!pix_q.lv) begin
                x <= '0;
            end else begin
                x <= x + 2'd1;
            end

            if (!pix_q.fv) begin
                y <= '0;
            end else if (lv_prev && !pix_q.lv) begin
                y <= y + 2'd1;
            end
        end
    end

    assign pos.frame_start = pix_q.fv && !fv_prev;
    assign pos.line_active = pix_q.fv && pix_q.lv;
    // One sample per 4x4 block
    assign pos.stat_sample = pix_q.lv && (x == 2'd0) && (y == 2'd0);

endmodule

`default_nettype wire

/* hw/capture_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_fsm (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        capture,
    input  logic                        skip_count,
    input  img_capture_pkg::frame_pos_t pos,
    input  img_capture_pkg::pixel_bus_t pix_q,
    input  logic                        header_last,
    output img_capture_pkg::word_sel_e  word_sel,
    output logic                        header_load,
    output logic                        frame_clear,
    output logic                        checksum_hold,
    output logic                        stat_en,
    output logic                        busy,
    output logic                        capture_done
);
    img_capture_pkg::capture_state_e state;
    logic                            skip_left;
    logic                            clear_q;
    // Checksum phases: 0 holds the sum, 1 and 2 emit its halves
    logic [1:0]                      sum_phase;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state        <= img_capture_pkg::ST_IDLE;
            skip_left    <= 1'b0;
            clear_q      <= 1'b0;
            sum_phase    <= '0;
            capture_done <= 1'b0;
        end else begin
            clear_q      <= 1'b0;
            capture_done <= 1'b0;
            case (state)
                img_capture_pkg::ST_IDLE: begin
                    if (capture) begin
                        state <= img_capture_pkg::ST_LOAD;
                    end
                end
                img_capture_pkg::ST_LOAD: begin
                    skip_left <= skip_count;
                    clear_q   <= 1'b1;
                    state     <= img_capture_pkg::ST_HEADER;
                end
                img_capture_pkg::ST_HEADER: begin
                    if (!clear_q && header_last) begin
                        state <= img_capture_pkg::ST_WAIT_FRAME;
                    end
                end
                img_capture_pkg::ST_WAIT_FRAME: begin
                    if (pos.frame_start) begin
                        state <= img_capture_pkg::ST_FRAME;
                    end
                end
                img_capture_pkg::ST_FRAME: begin
                    // Falling fv ends the frame
                    if (!pix_q.fv) begin
                        sum_phase <= '0;
                        state     <= img_capture_pkg::ST_CHECKSUM;
                    end
                end
                img_capture_pkg::ST_CHECKSUM: begin
                    sum_phase <= sum_phase + 2'd1;
                    if (sum_phase == 2'd2) begin
                        state <= img_capture_pkg::ST_NEXT;
                    end
                end
                img_capture_pkg::ST_NEXT: begin
                    if (skip_left) begin
                        skip_left <= skip_left - 1'b1;
                        clear_q   <= 1'b1;
                        state     <= img_capture_pkg::ST_HEADER;
                    end else begin
                        capture_done <= 1'b1;
                        state        <= img_capture_pkg::ST_IDLE;
                    end
                end
                default: state <= img_capture_pkg::ST_IDLE;
            endcase
        end
    end

    // Word source for this cycle
    always_comb begin
        word_sel = img_capture_pkg::WORD_NONE;
        case (state)
            img_capture_pkg::ST_HEADER: begin
                if (!clear_q) begin
                    word_sel = img_capture_pkg::WORD_HEADER;
                end
            end
            img_capture_pkg::ST_FRAME: begin
                if (pos.line_active) begin
                    word_sel = img_capture_pkg::WORD_PIXEL;
                end
            end
            img_capture_pkg::ST_CHECKSUM: begin
                if (sum_phase != 2'd0) begin
                    word_sel = img_capture_pkg::WORD_CHECKSUM;
                end
            end
            default: word_sel = img_capture_pkg::WORD_NONE;
        endcase
    end

    assign header_load   = clear_q;
    assign frame_clear   = clear_q;
    assign checksum_hold = (state == img_capture_pkg::ST_CHECKSUM) && (sum_phase == 2'd0);
    assign stat_en       = (state == img_capture_pkg::ST_FRAME);
    assign busy          = (state != img_capture_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hw/fletcher_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_capture_config.svh"

module fletcher_checksum (
    input  logic                           clk,
    input  logic                           readout_rst,
    input  logic                           clear,
    input  logic                           en,
    input  img_capture_pkg::capture_word_u din,
    output logic [31:0]                    sum
);
    logic [`IMG_WORD_BITS-1:0] sum_a;
    logic [`IMG_WORD_BITS-1:0] sum_b;
    logic [`IMG_WORD_BITS-1:0] next_a;

    // Addition modulo 65535; both operands stay below 2^16
    function automatic logic [`IMG_WORD_BITS-1:0] add_mod(
        input logic [`IMG_WORD_BITS-1:0] x,
        input logic [`IMG_WORD_BITS-1:0] y
    );
        logic [`IMG_WORD_BITS:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[`IMG_WORD_BITS-1:0];
    endfunction

    assign next_a = add_mod(sum_a, din.raw);

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            // b takes the updated a
            sum_b <= add_mod(sum_b, next_a);
        end
    end

    assign sum = {sum_b, sum_a};

endmodule

`default_nettype wire

/* hw/capture_word_stream.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_capture_config.svh"

module capture_word_stream (
    input  logic                                        clk,
    input  logic                                        readout_rst,
    input  logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header,
    input  img_capture_pkg::pixel_bus_t                 pix_q,
    input  img_capture_pkg::word_sel_e                  word_sel,
    input  logic                                        header_load,
    input  logic                                        frame_clear,
    input  logic                                        checksum_hold,
    input  logic [31:0]                                 checksum,
    output logic                                        header_last,
    output logic                                        word_valid,
    output img_capture_pkg::capture_word_u              word_data,
    output img_capture_pkg::capture_word_u              sum_word,
    output logic                                        sum_en,
    output logic [`IMG_COUNT_BITS-1:0]                  word_count
);
    localparam int HEADER_BITS = `IMG_HEADER_WORDS * `IMG_WORD_BITS;
    localparam int LEFT_BITS   = $clog2(`IMG_HEADER_WORDS + 1);

    logic [HEADER_BITS-1:0]        header_sr;
    logic [LEFT_BITS-1:0]          header_left;
    logic [31:0]                   sum_hold;
    img_capture_pkg::capture_word_u next_word;

    // ====================
    // Word select
    // ====================
    always_comb begin
        next_word.raw = header_sr[HEADER_BITS-1 -: `IMG_WORD_BITS];
        case (word_sel)
            img_capture_pkg::WORD_PIXEL: begin
                next_word.pixel.lo_byte   = pix_q.d[7:0];
                next_word.pixel.pad       = '0;
                next_word.pixel.hi_nibble = pix_q.d[`IMG_PIXEL_BITS-1:8];
            end
            img_capture_pkg::WORD_CHECKSUM: begin
                next_word.raw = {sum_hold[7:0], sum_hold[15:8]};
            end
            default: begin
            end
        endcase
    end

    // ====================
    // Control and counters
    // ====================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            header_left <= '0;
            word_valid  <= 1'b0;
            sum_en      <= 1'b0;
            word_count  <= '0;
        end else begin
            word_valid <= (word_sel != img_capture_pkg::WORD_NONE);
            sum_en     <= (word_sel == img_capture_pkg::WORD_HEADER) ||
                          (word_sel == img_capture_pkg::WORD_PIXEL);
            if (header_load) begin
                header_left <= LEFT_BITS'(`IMG_HEADER_WORDS - 1);
            end else if (word_sel == img_capture_pkg::WORD_HEADER) begin
                header_left <= header_left - 1'b1;
            end
            if (frame_clear) begin
                word_count <= '0;
            end else if (word_sel != img_capture_pkg::WORD_NONE) begin
                word_count <= word_count + 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        word_data    <= next_word;
        // Checksum sees the word as little-endian
        sum_word.raw <= {next_word.raw[7:0], next_word.raw[15:8]};
        if (header_load) begin
            header_sr <= header;
        end else if (word_sel == img_capture_pkg::WORD_HEADER) begin
            header_sr <= header_sr << `IMG_WORD_BITS;
        end
        // Low half goes out first
        if (checksum_hold) begin
            sum_hold <= checksum;
        end else if (word_sel == img_capture_pkg::WORD_CHECKSUM) begin
            sum_hold <= sum_hold >> 16;
        end
    end

    assign header_last = (header_left == '0);

endmodule

`default_nettype wire

/* hw/pixel_stats.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_capture_config.svh"

module pixel_stats (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        frame_clear,
    input  logic                        stat_en,
    input  img_capture_pkg::frame_pos_t pos,
    input  img_capture_pkg::pixel_bus_t pix_q,
    output logic [`IMG_STAT_BITS-1:0]   highlight_count,
    output logic [`IMG_STAT_BITS-1:0]   shadow_count
);
    logic [`IMG_STAT_TOP_BITS-1:0] top_bits;
    logic                          sample;

    // Only the upper bits decide highlight or shadow
    assign top_bits = pix_q.d[`IMG_PIXEL_BITS-1 -: `IMG_STAT_TOP_BITS];
    assign sample   = stat_en && pos.stat_sample;

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (frame_clear) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (sample) begin
            if (&top_bits) begin
                highlight_count <= highlight_count + 1'b1;
            end
            if (~|top_bits) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/img_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_capture_config.svh"

module img_capture_top (
    input  logic                            clk,
    input  logic                            readout_rst,
    input  img_capture_pkg::capture_cmd_t   cmd,
    input  img_capture_pkg::pixel_bus_t     pix,
    output logic                            word_valid,
    output img_capture_pkg::capture_word_u  word_data,
    output logic                            busy,
    output logic                            capture_done,
    output img_capture_pkg::capture_stats_t stats
);
    img_capture_pkg::pixel_bus_t    pix_q;
    img_capture_pkg::frame_pos_t    pos;
    img_capture_pkg::word_sel_e     word_sel;
    img_capture_pkg::capture_word_u sum_word;
    logic                           header_load;
    logic                           frame_clear;
    logic                           checksum_hold;
    logic                           stat_en;
    logic                           header_last;
    logic                           sum_en;
    logic [31:0]                    checksum;
    logic [`IMG_COUNT_BITS-1:0]     word_count;
    logic [`IMG_STAT_BITS-1:0]      highlight_count;
    logic [`IMG_STAT_BITS-1:0]      shadow_count;

    frame_position_counter pos0 (
        .clk(clk), .readout_rst(readout_rst), .pix(pix), .pix_q(pix_q), .pos(pos)
    );

    capture_fsm fsm0 (
        .clk(clk), .readout_rst(readout_rst), .capture(cmd.capture),
        .skip_count(cmd.skip_count), .pos(pos), .pix_q(pix_q), .header_last(header_last),
        .word_sel(word_sel), .header_load(header_load), .frame_clear(frame_clear),
        .checksum_hold(checksum_hold), .stat_en(stat_en), .busy(busy),
        .capture_done(capture_done)
    );

    capture_word_stream stream0 (
        .clk(clk), .readout_rst(readout_rst), .header(cmd.header), .pix_q(pix_q),
        .word_sel(word_sel), .header_load(header_load), .frame_clear(frame_clear),
        .checksum_hold(checksum_hold), .checksum(checksum), .header_last(header_last),
        .word_valid(word_valid), .word_data(word_data), .sum_word(sum_word),
        .sum_en(sum_en), .word_count(word_count)
    );

    fletcher_checksum sum0 (
        .clk(clk), .readout_rst(readout_rst), .clear(frame_clear), .en(sum_en),
        .din(sum_word), .sum(checksum)
    );

    pixel_stats stats0 (
        .clk(clk), .readout_rst(readout_rst), .frame_clear(frame_clear), .stat_en(stat_en),
        .pos(pos), .pix_q(pix_q), .highlight_count(highlight_count),
        .shadow_count(shadow_count)
    );

    assign stats.word_count      = word_count;
    assign stats.highlight_count = highlight_count;
    assign stats.shadow_count    = shadow_count;

endmodule

`default_nettype wire

/* verif/img_capture_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module img_capture_checker (
    input logic clk,
    input logic readout_rst,
    input logic word_valid,
    input logic busy,
    input logic capture_done
);

    // Failed assertions so far
    int fail_count = 0;

    // ====================
    // Output protocol
    // ====================
    a_valid_busy: assert property (@(posedge clk) disable iff (!readout_rst)
        word_valid |-> busy)
        else begin
            fail_count++;
            $error("word_valid high while busy is low");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!readout_rst)
        capture_done |=> !capture_done)
        else begin
            fail_count++;
            $error("capture_done longer than one cycle");
        end

    // Outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        !readout_rst |=> (!word_valid && !busy && !capture_done))
        else begin
            fail_count++;
            $error("outputs active in the cycle after reset");
        end

endmodule

bind img_capture_top img_capture_checker checker0 (
    .clk(clk), .readout_rst(readout_rst), .word_valid(word_valid), .busy(busy),
    .capture_done(capture_done)
);

`default_nettype wire

/* verif/img_capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "img_capture_config.svh"

module img_capture_tb;

    localparam int NUM_TESTS = 5;
    localparam int LINE_GAP  = 3;
    localparam int FRAME_GAP = 16;

    typedef enum logic [1:0] {
        MODE_LFSR,
        MODE_HIGH,
        MODE_SHADOW,
        MODE_RAMP
    } pix_mode_e;

    typedef struct packed {
        logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] header;
        logic                                        skip_count;
        logic [7:0]                                  width;
        logic [7:0]                                  lines;
        pix_mode_e                                   mode;
    } test_row_t;

    logic                            clk;
    logic                            readout_rst;
    img_capture_pkg::capture_cmd_t   cmd;
    img_capture_pkg::pixel_bus_t     pix;
    logic                            word_valid;
    img_capture_pkg::capture_word_u  word_data;
    logic                            busy;
    logic                            capture_done;
    img_capture_pkg::capture_stats_t stats;

    test_row_t   table_rows [NUM_TESTS];
    logic [31:0] lfsr;
    logic [15:0] exp_words [$];
    logic [11:0] pix_vals [$];
    logic [15:0] exp_word;
    int          errors;
    int          failed_tests;
    int          done_count;
    int          cycle_count;
    int          cycle_limit;
    int          exp_high;
    int          exp_shadow;
    int          exp_count;

    img_capture_top dut0 (
        .clk(clk), .readout_rst(readout_rst), .cmd(cmd), .pix(pix),
        .word_valid(word_valid), .word_data(word_data), .busy(busy),
        .capture_done(capture_done), .stats(stats)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ====================
    // Model
    // ====================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [11:0] random_pixel();
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[10:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] swap_bytes(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    // Expected word stream, pixel values and last frame's stats
    task automatic build_expected(input test_row_t row);
        logic [15:0] w;
        logic [11:0] d;
        int          a;
        int          b;
        exp_words.delete();
        pix_vals.delete();
        for (int f = 0; f <= row.skip_count; f++) begin
            a = 0;
            b = 0;
            exp_high = 0;
            exp_shadow = 0;
            for (int k = `IMG_HEADER_WORDS - 1; k >= 0; k--) begin
                w = row.header[k*16 +: 16];
                exp_words.push_back(w);
                a = (a + swap_bytes(w)) % 65535;
                b = (b + a) % 65535;
            end
            for (int j = 0; j < row.lines; j++) begin
                for (int i = 0; i < row.width; i++) begin
                    case (row.mode)
                        MODE_LFSR:   d = random_pixel();
                        MODE_HIGH:   d = 12'hFE3;
                        MODE_SHADOW: d = 12'h01D;
                        default:     d = 12'((j * row.width + i) * 37);
                    endcase
                    pix_vals.push_back(d);
                    exp_words.push_back({d[7:0], 4'h0, d[11:8]});
                    a = (a + d) % 65535;
                    b = (b + a) % 65535;
                    // Grid sample every fourth pixel of every fourth line
                    if (i % 4 == 0 && j % 4 == 0 && d[11:5] == 7'h7F) begin
                        exp_high++;
                    end
                    if (i % 4 == 0 && j % 4 == 0 && d[11:5] == 7'h00) begin
                        exp_shadow++;
                    end
                end
            end
            exp_words.push_back(swap_bytes(a[15:0]));
            exp_words.push_back(swap_bytes(b[15:0]));
        end
        exp_count = `IMG_HEADER_WORDS + row.lines * row.width + 2;
    endtask

    // ====================
    // Pixel source
    // ====================
    task automatic drive_frames(input test_row_t row);
        for (int f = 0; f <= row.skip_count; f++) begin
            repeat (FRAME_GAP) @(posedge clk);
            #1;
            pix.fv = 1'b1;
            repeat (2) @(posedge clk);
            for (int j = 0; j < row.lines; j++) begin
                for (int i = 0; i < row.width; i++) begin
                    @(posedge clk);
                    #1;
                    pix.lv = 1'b1;
                    pix.d  = pix_vals.pop_front();
                end
                repeat (LINE_GAP) begin
                    @(posedge clk);
                    #1;
                    pix.lv = 1'b0;
                end
            end
            pix.fv = 1'b0;
        end
    endtask

    // Compares each output word with the next expected word
    always @(negedge clk) begin
        if (readout_rst && word_valid) begin
            if (exp_words.size() == 0) begin
                $display("Unexpected word 0x%h after the end of the stream", word_data.raw);
                errors++;
            end else begin
                exp_word = exp_words.pop_front();
                if (word_data.raw !== exp_word) begin
                    $display("** Error: word_data = 0x%h, expected 0x%h",
                             word_data.raw, exp_word);
                    errors++;
                end
            end
        end
        if (readout_rst && capture_done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles while waiting for capture_done", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic run_test(input int n, input test_row_t row);
        int start_errors;
        start_errors = errors;
        build_expected(row);
        done_count = 0;
        @(posedge clk);
        #1;
        cmd.header     = row.header;
        cmd.skip_count = row.skip_count;
        cmd.capture    = 1'b1;
        @(posedge clk);
        #1;
        cmd.capture = 1'b0;
        drive_frames(row);
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (exp_words.size() != 0) begin
            $display("%0d expected words never arrived", exp_words.size());
            errors++;
        end
        if (done_count != 1) begin
            $display("capture_done pulsed %0d times instead of once", done_count);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("busy still high after capture_done");
            errors++;
        end
        if (stats.word_count !== exp_count) begin
            $display("** Error: stats.word_count = 0x%h, expected 0x%h",
                     stats.word_count, exp_count);
            errors++;
        end
        if (stats.highlight_count !== exp_high) begin
            $display("** Error: stats.highlight_count = 0x%h, expected 0x%h",
                     stats.highlight_count, exp_high);
            errors++;
        end
        if (stats.shadow_count !== exp_shadow) begin
            $display("** Error: stats.shadow_count = 0x%h, expected 0x%h",
                     stats.shadow_count, exp_shadow);
            errors++;
        end

        if (errors == start_errors) begin
            $display("Test %0d: %0d x %0d, skip %0d, ok", n, row.width, row.lines,
                     row.skip_count);
        end else begin
            failed_tests++;
            $display("Test %0d: %0d x %0d, skip %0d, FAILED", n, row.width, row.lines,
                     row.skip_count);
        end
    endtask

    initial begin
        int total;
        readout_rst  = 1'b0;
        cmd          = '0;
        pix          = '0;
        lfsr         = 32'd95830;
        errors       = 0;
        failed_tests = 0;
        done_count   = 0;
        cycle_count  = 0;
        cycle_limit  = 0;

        // header, skip_count, width, lines, mode
        table_rows[0] = '{64'h0123_4567_89AB_CDEF, 1'b0, 8'd8, 8'd5, MODE_LFSR};
        table_rows[1] = '{64'hFFFF_0000_A5A5_5A5A, 1'b0, 8'd9, 8'd6, MODE_HIGH};
        table_rows[2] = '{64'h1357_9BDF_2468_ACE0, 1'b0, 8'd6, 8'd5, MODE_SHADOW};
        table_rows[3] = '{64'h0F0F_F0F0_3C3C_C3C3, 1'b1, 8'd10, 8'd8, MODE_LFSR};
        table_rows[4] = '{64'h7E81_00FF_FF00_8001, 1'b0, 8'd7, 8'd6, MODE_RAMP};

        total = 10;
        for (int n = 0; n < NUM_TESTS; n++) begin
            total += (table_rows[n].skip_count + 1) * (FRAME_GAP + 14 +
                     table_rows[n].lines * (table_rows[n].width + LINE_GAP)) + 10;
        end
        cycle_limit = 2 * total + 200;

        repeat (10) @(posedge clk);
        #1;
        readout_rst = 1'b1;
        @(negedge clk);
        if (word_valid !== 1'b0 || busy !== 1'b0 || capture_done !== 1'b0) begin
            $display("word_valid, busy or capture_done is high after reset");
            errors++;
        end
        if (stats !== '0) begin
            $display("** Error: stats = 0x%h, expected 0x0", stats);
            errors++;
        end

        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n, table_rows[n]);
        end

        if (dut0.checker0.fail_count != 0) begin
            $display("%0d protocol assertion failures in the bound checker",
                     dut0.checker0.fail_count);
            errors += dut0.checker0.fail_count;
        end

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hw
hw/img_capture_pkg.sv
hw/frame_position_counter.sv
hw/capture_fsm.sv
hw/fletcher_checksum.sv
hw/capture_word_stream.sv
hw/pixel_stats.sv
hw/img_capture_top.sv
verif/img_capture_checker.sv
verif/img_capture_tb.sv
